//--- hdl/beeb_host.sv
//==========================================================
// host side glue for the bbc micro / master 128 core
// memory with rom loader, mouse joystick emulation, routing
// sizes of ram and mouse step are set here
//==========================================================

module beeb_host #(
	parameter int RAM_DEPTH      = 212992,
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             machine_reset,
	input  logic                             model_master,
	input  logic                             mmfs_v2,
	input  logic                             load_wr,
	input  logic [beeb_pkg::LOAD_ADDR_W-1:0] load_addr,
	input  logic [7:0]                       load_data,
	input  beeb_pkg::mem_addr_t              mem_addr,
	input  logic                             mem_we_n,
	input  logic [7:0]                       mem_wdata,
	input  logic [beeb_pkg::MOUSE_PKT_W-1:0] mouse_packet,
	input  logic                             mouse_disable,
	input  logic [15:0]                      joy1_buttons,
	input  logic [beeb_pkg::AXIS_W-1:0]      joy1_x,
	input  logic [beeb_pkg::AXIS_W-1:0]      joy1_y,
	input  logic [15:0]                      joy2_buttons,
	input  logic [beeb_pkg::AXIS_W-1:0]      joy2_x,
	input  logic [beeb_pkg::AXIS_W-1:0]      joy2_y,
	input  logic                             swap_joysticks,
	output logic [7:0]                       mem_rdata,
	output logic [beeb_pkg::JS_W-1:0]        js1_x,
	output logic [beeb_pkg::JS_W-1:0]        js1_y,
	output logic                             js1_fire_n,
	output logic [beeb_pkg::JS_W-1:0]        js2_x,
	output logic [beeb_pkg::JS_W-1:0]        js2_y,
	output logic                             js2_fire_n
);

	// registered mouse state into the router
	logic                        emu_active;
	logic [beeb_pkg::AXIS_W-1:0] mouse_x;
	logic [beeb_pkg::AXIS_W-1:0] mouse_y;
	logic                        mouse_fire;

	beeb_memory #(
		.RAM_DEPTH (RAM_DEPTH)
	) u_memory (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.machine_reset (machine_reset),
		.model_master  (model_master),
		.mmfs_v2       (mmfs_v2),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.mem_addr      (mem_addr),
		.mem_we_n      (mem_we_n),
		.mem_wdata     (mem_wdata),
		.mem_rdata     (mem_rdata)
	);

	mouse_joystick #(
		.MOUSE_STEP_MAX (MOUSE_STEP_MAX)
	) u_mouse (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.machine_reset (machine_reset),
		.mouse_packet  (mouse_packet),
		.mouse_disable (mouse_disable),
		.joy1_buttons  (joy1_buttons),
		.emu_active    (emu_active),
		.mouse_x       (mouse_x),
		.mouse_y       (mouse_y),
		.mouse_fire    (mouse_fire)
	);

	joystick_router u_router (
		.emu_active     (emu_active),
		.mouse_x        (mouse_x),
		.mouse_y        (mouse_y),
		.mouse_fire     (mouse_fire),
		.joy1_buttons   (joy1_buttons),
		.joy1_x         (joy1_x),
		.joy1_y         (joy1_y),
		.joy2_buttons   (joy2_buttons),
		.joy2_x         (joy2_x),
		.joy2_y         (joy2_y),
		.swap_joysticks (swap_joysticks),
		.js1_x          (js1_x),
		.js1_y          (js1_y),
		.js1_fire_n     (js1_fire_n),
		.js2_x          (js2_x),
		.js2_y          (js2_y),
		.js2_fire_n     (js2_fire_n)
	);

endmodule

//--- hdl/beeb_memory.sv
//==========================================================
// paged rom and ram behind the cpu memory port
// rom is filled from the download port during machine reset
// ram takes one write per falling edge of mem_we_n
// read data is valid one cycle after the address
//==========================================================

module beeb_memory #(
	parameter int RAM_DEPTH = 212992
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             machine_reset,
	input  logic                             model_master,
	input  logic                             mmfs_v2,
	input  logic                             load_wr,
	input  logic [beeb_pkg::LOAD_ADDR_W-1:0] load_addr,
	input  logic [7:0]                       load_data,
	input  beeb_pkg::mem_addr_t              mem_addr,
	input  logic                             mem_we_n,
	input  logic [7:0]                       mem_wdata,
	output logic [7:0]                       mem_rdata
);

	localparam int ROM_BYTES = beeb_pkg::ROM_SLOTS * (1 << beeb_pkg::OFFSET_W);

	logic                        m128;
	logic [beeb_pkg::PAGE_W-1:0] slot;
	logic                        mapped;
	logic                        we_n_q;
	logic                        ram_ok;
	logic                        ram_we;
	logic                        sel_ram_q;
	logic                        mapped_q;
	logic                        ram_ok_q;
	logic [7:0]                  rom_rdata;
	logic [7:0]                  ram_rdata;

	logic [7:0] rom_mem [ROM_BYTES];
	logic [7:0] ram_mem [RAM_DEPTH];

	// model only changes while the machine is held in reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			m128 <= 1'b0;
		end else if (machine_reset) begin
			m128 <= model_master;
		end
	end

	rom_slot_map u_slot_map (
		.m128    (m128),
		.mmfs_v2 (mmfs_v2),
		.page    (mem_addr.rom.page),
		.slot    (slot),
		.mapped  (mapped)
	);

	//==========================================================
	// rom array
	//==========================================================
	// loader owns the write port, cpu only reads
	always_ff @(posedge clk_sys) begin
		if (machine_reset && load_wr) begin
			rom_mem[load_addr] <= load_data;
		end
		rom_rdata <= rom_mem[{slot, mem_addr.rom.offset}];
	end

	//==========================================================
	// ram array
	//==========================================================
	// previous strobe level for edge detect
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	// addresses past the ram depth are dropped
	assign ram_ok = (mem_addr.ram.ram_addr < RAM_DEPTH);
	// first low cycle of the strobe, ram view only
	assign ram_we = mem_addr.ram.ram_sel && we_n_q && !mem_we_n && ram_ok;

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram_mem[mem_addr.ram.ram_addr] <= mem_wdata;
		end
		ram_rdata <= ram_mem[mem_addr.ram.ram_addr];
	end

	//==========================================================
	// read data select
	//==========================================================
	// decode flags follow the address into the read cycle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sel_ram_q <= 1'b0;
			mapped_q  <= 1'b0;
			ram_ok_q  <= 1'b0;
		end else begin
			sel_ram_q <= mem_addr.ram.ram_sel;
			mapped_q  <= mapped;
			ram_ok_q  <= ram_ok;
		end
	end

	always_comb begin
		if (sel_ram_q) begin
			mem_rdata = ram_ok_q ? ram_rdata : 8'h00;
		end else if (mapped_q) begin
			mem_rdata = rom_rdata;
		end else begin
			// empty rom page
			mem_rdata = 8'h00;
		end
	end

endmodule

//--- hdl/beeb_pkg.sv
//==========================================================
// shared widths, limits and types for the beeb host glue
// referenced by scoped name from the RTL and the testbench
// the cpu address is one word decoded as a rom or ram view
//==========================================================

package beeb_pkg;

	// rom paging
	localparam int PAGE_W      = 4;
	localparam int OFFSET_W    = 14;
	localparam int ROM_SLOTS   = 16;
	localparam int LOAD_ADDR_W = 18;
	localparam int RAM_ADDR_W  = 18;

	// analog axes and routed outputs
	localparam int AXIS_W   = 8;
	localparam int JS_W     = 12;
	localparam int AXIS_MIN = -128;
	localparam int AXIS_MAX = 127;
	localparam int JOY_FIRE = 4;

	//==========================================================
	// mouse packet layout
	//==========================================================
	localparam int MOUSE_PKT_W  = 25;
	localparam int MOUSE_BTN_LO = 0;
	localparam int MOUSE_XSIGN  = 4;
	localparam int MOUSE_YSIGN  = 5;
	localparam int MOUSE_DX_LO  = 9;
	localparam int MOUSE_DY_LO  = 17;
	localparam int MOUSE_STB    = 24;

	// paged rom view: top bit, logical page, byte offset
	typedef struct packed {
		logic                ram_sel;
		logic [PAGE_W-1:0]   page;
		logic [OFFSET_W-1:0] offset;
	} rom_view_t;

	// flat ram view of the same word
	typedef struct packed {
		logic                  ram_sel;
		logic [RAM_ADDR_W-1:0] ram_addr;
	} ram_view_t;

	typedef union packed {
		rom_view_t rom;
		ram_view_t ram;
	} mem_addr_t;

endpackage

//--- hdl/joystick_router.sv
//==========================================================
// routes mouse or joystick axes onto the two analog ports
// signed axes become inverted 12 bit values, fire active low
// swap exchanges port 1 and port 2
//==========================================================

module joystick_router (
	input  logic                        emu_active,
	input  logic [beeb_pkg::AXIS_W-1:0] mouse_x,
	input  logic [beeb_pkg::AXIS_W-1:0] mouse_y,
	input  logic                        mouse_fire,
	input  logic [15:0]                 joy1_buttons,
	input  logic [beeb_pkg::AXIS_W-1:0] joy1_x,
	input  logic [beeb_pkg::AXIS_W-1:0] joy1_y,
	input  logic [15:0]                 joy2_buttons,
	input  logic [beeb_pkg::AXIS_W-1:0] joy2_x,
	input  logic [beeb_pkg::AXIS_W-1:0] joy2_y,
	input  logic                        swap_joysticks,
	output logic [beeb_pkg::JS_W-1:0]   js1_x,
	output logic [beeb_pkg::JS_W-1:0]   js1_y,
	output logic                        js1_fire_n,
	output logic [beeb_pkg::JS_W-1:0]   js2_x,
	output logic [beeb_pkg::JS_W-1:0]   js2_y,
	output logic                        js2_fire_n
);

	localparam int AW = beeb_pkg::AXIS_W;
	localparam int XW = beeb_pkg::JS_W - beeb_pkg::AXIS_W;

	logic [beeb_pkg::JS_W-1:0] a_x;
	logic [beeb_pkg::JS_W-1:0] a_y;
	logic [beeb_pkg::JS_W-1:0] b_x;
	logic [beeb_pkg::JS_W-1:0] b_y;
	logic                      a_fire;
	logic                      b_fire;

	// signed to offset binary, flipped, top bits repeated below
	function automatic logic [beeb_pkg::JS_W-1:0] conv(input logic [AW-1:0] axis);
		logic [AW-1:0] v;
		v = {AW{1'b1}} - (axis ^ AW'(1 << (AW - 1)));
		return {v, v[AW-1 -: XW]};
	endfunction

	// source a, mouse while emulating else joystick 1
	assign a_x    = conv(emu_active ? mouse_x : joy1_x);
	assign a_y    = conv(emu_active ? mouse_y : joy1_y);
	assign a_fire = emu_active ? mouse_fire : joy1_buttons[beeb_pkg::JOY_FIRE];

	// source b, always joystick 2
	assign b_x    = conv(joy2_x);
	assign b_y    = conv(joy2_y);
	assign b_fire = joy2_buttons[beeb_pkg::JOY_FIRE];

	assign js1_x      = swap_joysticks ? b_x : a_x;
	assign js1_y      = swap_joysticks ? b_y : a_y;
	assign js1_fire_n = ~(swap_joysticks ? b_fire : a_fire);
	assign js2_x      = swap_joysticks ? a_x : b_x;
	assign js2_y      = swap_joysticks ? a_y : b_y;
	assign js2_fire_n = ~(swap_joysticks ? a_fire : b_fire);

endmodule

//--- hdl/mouse_joystick.sv
//==========================================================
// mouse driven analog joystick emulation
// each new packet adds a clamped delta to saturating axes
// any joystick 1 button, disable or machine reset cancels it
// axes move two cycles after the packet strobe toggles
//==========================================================

module mouse_joystick #(
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             machine_reset,
	input  logic [beeb_pkg::MOUSE_PKT_W-1:0] mouse_packet,
	input  logic                             mouse_disable,
	input  logic [15:0]                      joy1_buttons,
	output logic                             emu_active,
	output logic [beeb_pkg::AXIS_W-1:0]      mouse_x,
	output logic [beeb_pkg::AXIS_W-1:0]      mouse_y,
	output logic                             mouse_fire
);

	logic [beeb_pkg::MOUSE_PKT_W-1:0]   pkt_q;
	logic                               stb_q;
	logic                               new_pkt;
	logic                               clear;
	logic signed [8:0]                  dx;
	logic signed [8:0]                  dy;
	logic signed [9:0]                  nx;
	logic signed [9:0]                  ny;
	logic signed [beeb_pkg::AXIS_W-1:0] ax_q;
	logic signed [beeb_pkg::AXIS_W-1:0] ay_q;

	// limit one packet's movement
	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] d);
		if (d > MOUSE_STEP_MAX) begin
			return 9'(MOUSE_STEP_MAX);
		end else if (d < -MOUSE_STEP_MAX) begin
			return 9'(-MOUSE_STEP_MAX);
		end
		return d;
	endfunction

	// pin the running sum to the axis range
	function automatic logic signed [beeb_pkg::AXIS_W-1:0] sat_axis(
		input logic signed [9:0] v
	);
		if (v < beeb_pkg::AXIS_MIN) begin
			return beeb_pkg::AXIS_W'(beeb_pkg::AXIS_MIN);
		end else if (v > beeb_pkg::AXIS_MAX) begin
			return beeb_pkg::AXIS_W'(beeb_pkg::AXIS_MAX);
		end
		return v[beeb_pkg::AXIS_W-1:0];
	endfunction

	//==========================================================
	// packet capture and strobe edge
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pkt_q <= '0;
			stb_q <= 1'b0;
		end else begin
			pkt_q <= mouse_packet;
			stb_q <= pkt_q[beeb_pkg::MOUSE_STB];
		end
	end

	assign new_pkt = pkt_q[beeb_pkg::MOUSE_STB] != stb_q;
	assign clear   = mouse_disable || (|joy1_buttons) || machine_reset;

	// sign bit doubled over seven magnitude bits
	assign dx = clamp_step({{2{pkt_q[beeb_pkg::MOUSE_XSIGN]}},
		pkt_q[beeb_pkg::MOUSE_DX_LO +: 7]});
	assign dy = clamp_step({{2{pkt_q[beeb_pkg::MOUSE_YSIGN]}},
		pkt_q[beeb_pkg::MOUSE_DY_LO +: 7]});

	// mouse y grows upward, joystick y downward
	assign nx = ax_q + dx;
	assign ny = ay_q - dy;

	//==========================================================
	// accumulated axes
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n || clear) begin
			emu_active <= 1'b0;
			ax_q       <= '0;
			ay_q       <= '0;
		end else if (new_pkt) begin
			emu_active <= 1'b1;
			ax_q       <= sat_axis(nx);
			ay_q       <= sat_axis(ny);
		end
	end

	assign mouse_x    = ax_q;
	assign mouse_y    = ay_q;
	// either mouse button fires
	assign mouse_fire = |pkt_q[beeb_pkg::MOUSE_BTN_LO +: 2];

endmodule

//--- hdl/rom_slot_map.sv
//==========================================================
// logical rom page to physical slot lookup
// pure combinational, driven from the cpu address page bits
// mapped low means the page has no rom and reads as zero
//==========================================================

module rom_slot_map (
	input  logic                        m128,
	input  logic                        mmfs_v2,
	input  logic [beeb_pkg::PAGE_W-1:0] page,
	output logic [beeb_pkg::PAGE_W-1:0] slot,
	output logic                        mapped
);

	localparam int W = beeb_pkg::PAGE_W;

	always_comb begin
		// default to slot 0, mapped, unless the case says otherwise
		slot   = '0;
		mapped = 1'b1;
		if (!m128) begin
			//==================================================
			// model b
			//==================================================
			case (page)
				// dfs
				W'(3): slot = W'(4);
				// os high rom
				W'(4): slot = W'(0);
				// mmfs lives in page 8 for the split ram/rom
				W'(8): slot = mmfs_v2 ? W'(14) : W'(1);
				W'(14): slot = W'(2);
				// basic
				W'(15): slot = W'(3);
				default: mapped = 1'b0;
			endcase
		end else begin
			//==================================================
			// master 128
			//==================================================
			case (page)
				// mammfs, v2 image kept in the top slot
				W'(3): slot = mmfs_v2 ? W'(15) : W'(5);
				// mos
				W'(4): slot = W'(6);
				// pages 9..15 packed into slots 7..13
				W'(9), W'(10), W'(11), W'(12), W'(13), W'(14), W'(15):
					slot = page - W'(2);
				default: mapped = 1'b0;
			endcase
		end
	end

endmodule

//--- list.f
hdl/beeb_pkg.sv
hdl/rom_slot_map.sv
hdl/beeb_memory.sv
hdl/mouse_joystick.sv
hdl/joystick_router.sv
hdl/beeb_host.sv
tb/tb_clock.sv
tb/beeb_host_properties.sv
tb/tb_beeb_host.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f list.f --top-module tb_beeb_host -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && exit 0 || exit 1

//--- tb/beeb_host_properties.sv
//==========================================================
// concurrent checks bound onto the beeb host top level
// empty rom pages, unknown read data, swapped port routing
//==========================================================

module beeb_host_properties (
	input logic                        clk_sys,
	input logic                        rst_n,
	input beeb_pkg::mem_addr_t         mem_addr,
	input logic [7:0]                  mem_rdata,
	input logic                        swap_joysticks,
	input logic                        mouse_disable,
	input logic [beeb_pkg::AXIS_W-1:0] joy2_x,
	input logic [beeb_pkg::JS_W-1:0]   js1_x
);

	timeunit 1ns;
	timeprecision 100ps;

	logic empty_page;
	logic [beeb_pkg::JS_W-1:0] joy2_conv;
	logic [7:0] v;

	// failed assertions so far, read by the testbench at the end
	int fail_count = 0;

	// pages 0-2 and 5-7 hold no rom in either model
	assign empty_page = !mem_addr.rom.ram_sel &&
		(mem_addr.rom.page inside {4'd0, 4'd1, 4'd2, 4'd5, 4'd6, 4'd7});

	// 255 minus offset binary, top nibble repeated
	assign v         = 8'hff - (joy2_x ^ 8'h80);
	assign joy2_conv = {v, v[7:4]};

	a_empty_page_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		empty_page |=> mem_rdata == 8'h00)
		else begin
			fail_count++;
			$error("empty rom page read returned nonzero data");
		end

	a_rdata_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(mem_rdata))
		else begin
			fail_count++;
			$error("mem_rdata unknown after reset");
		end

	a_swap_port1: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(swap_joysticks && mouse_disable) |-> js1_x == joy2_conv)
		else begin
			fail_count++;
			$error("js1_x does not follow joystick 2 when swapped");
		end

endmodule

bind beeb_host beeb_host_properties u_props (.*);

//--- tb/tb_beeb_host.sv
//==========================================================
// testbench for the beeb host glue
// a table of rows is built with expected values from a
// reference model, then applied in order on falling edges
//==========================================================

module tb_beeb_host;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_MODEL = 0;
	localparam int K_LOAD  = 1;
	localparam int K_READ  = 2;
	localparam int K_WRITE = 3;
	localparam int K_MOUSE = 4;
	localparam int K_JOY   = 5;
	localparam int JW      = beeb_pkg::JS_W;

	typedef struct {
		int          kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [JW-1:0] e0;
		logic [JW-1:0] e1;
		logic [JW-1:0] e2;
		logic [JW-1:0] e3;
		logic [JW-1:0] e4;
		logic [JW-1:0] e5;
	} row_t;

	logic clk_sys;
	logic rst_n;
	logic machine_reset;
	logic model_master;
	logic mmfs_v2;
	logic load_wr;
	logic [beeb_pkg::LOAD_ADDR_W-1:0] load_addr;
	logic [7:0] load_data;
	beeb_pkg::mem_addr_t mem_addr;
	logic mem_we_n;
	logic [7:0] mem_wdata;
	logic [beeb_pkg::MOUSE_PKT_W-1:0] mouse_packet;
	logic mouse_disable;
	logic [15:0] joy1_buttons;
	logic [7:0] joy1_x;
	logic [7:0] joy1_y;
	logic [15:0] joy2_buttons;
	logic [7:0] joy2_x;
	logic [7:0] joy2_y;
	logic swap_joysticks;
	logic [7:0] mem_rdata;
	logic [JW-1:0] js1_x;
	logic [JW-1:0] js1_y;
	logic js1_fire_n;
	logic [JW-1:0] js2_x;
	logic [JW-1:0] js2_y;
	logic js2_fire_n;

	row_t rows[$];
	logic stb;

	//==========================================================
	// reference model state
	//==========================================================
	logic [7:0] rom_ref [int];
	logic [7:0] ram_ref [int];
	logic [31:0] rnd;
	logic m_m128;
	logic m_mmfs;
	logic m_emu;
	int   m_x;
	int   m_y;
	logic [1:0] m_btn;
	logic m_dis;
	logic m_swap;
	logic [15:0] m_j1b;
	logic [15:0] m_j2b;
	logic [7:0] m_j1x;
	logic [7:0] m_j1y;
	logic [7:0] m_j2x;
	logic [7:0] m_j2y;

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	beeb_host dut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// slot table, -1 for an empty page
	function automatic int slot_ref(input int page);
		if (!m_m128) begin
			case (page)
				3: return 4;
				4: return 0;
				8: return m_mmfs ? 14 : 1;
				14: return 2;
				15: return 3;
				default: return -1;
			endcase
		end
		if (page == 3)
			return m_mmfs ? 15 : 5;
		if (page == 4)
			return 6;
		if (page >= 9)
			return page - 2;
		return -1;
	endfunction

	function automatic logic [JW-1:0] conv_ref(input logic [7:0] axis);
		logic [7:0] v;
		v = 8'd255 - (axis ^ 8'h80);
		return {v, v[7:4]};
	endfunction

	// one bit level widened for check_axis
	function automatic logic [JW-1:0] fire_level(input logic lvl);
		return {{(JW-1){1'b0}}, lvl};
	endfunction

	function automatic int clamp_ref(input logic [7:0] d);
		int v;
		v = $signed(d);
		if (v > 10)
			return 10;
		if (v < -10)
			return -10;
		return v;
	endfunction

	function automatic int sat_ref(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	function automatic void add_row(input int kind, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c, input logic [JW-1:0] e0,
		input logic [JW-1:0] e1, input logic [JW-1:0] e2, input logic [JW-1:0] e3,
		input logic [JW-1:0] e4, input logic [JW-1:0] e5);
		row_t r;
		r.kind = kind;
		r.a    = a;
		r.b    = b;
		r.c    = c;
		r.e0   = e0;
		r.e1   = e1;
		r.e2   = e2;
		r.e3   = e3;
		r.e4   = e4;
		r.e5   = e5;
		rows.push_back(r);
	endfunction

	// expected port values from the routing rule
	function automatic void add_route_row(input int kind, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		logic [7:0] ax;
		logic [7:0] ay;
		logic af;
		logic bf;
		ax = m_emu ? 8'(m_x) : m_j1x;
		ay = m_emu ? 8'(m_y) : m_j1y;
		af = m_emu ? (|m_btn) : m_j1b[4];
		bf = m_j2b[4];
		if (m_swap) begin
			add_row(kind, a, b, c, conv_ref(m_j2x), conv_ref(m_j2y), fire_level(!bf),
				conv_ref(ax), conv_ref(ay), fire_level(!af));
		end else begin
			add_row(kind, a, b, c, conv_ref(ax), conv_ref(ay), fire_level(!af),
				conv_ref(m_j2x), conv_ref(m_j2y), fire_level(!bf));
		end
	endfunction

	function automatic void add_model(input logic master, input logic mmfs);
		m_m128 = master;
		m_mmfs = mmfs;
		m_emu  = 1'b0;
		m_x    = 0;
		m_y    = 0;
		add_row(K_MODEL, 32'(master), 32'(mmfs), 0, 0, 0, 0, 0, 0, 0);
	endfunction

	function automatic void add_load(input int slot, input int off, input logic held);
		int idx;
		idx = slot * 16384 + off;
		rnd = xorshift(rnd);
		if (held)
			rom_ref[idx] = rnd[7:0];
		add_row(K_LOAD, 32'(idx), 32'(!held), 32'(rnd[7:0]), 0, 0, 0, 0, 0, 0);
	endfunction

	function automatic void add_rom_read(input int page, input int off);
		int s;
		logic [7:0] e;
		s = slot_ref(page);
		e = (s < 0) ? 8'h00 : rom_ref[s * 16384 + off];
		add_row(K_READ, {13'd0, 1'b0, 4'(page), 14'(off)}, 0, 0, JW'(e), 0, 0, 0, 0, 0);
	endfunction

	function automatic void add_ram_write(input logic [18:0] addr, input logic [7:0] d1,
		input logic [7:0] d2);
		// only the first value of a held strobe lands
		if (addr[18])
			ram_ref[int'(addr[17:0])] = d1;
		add_row(K_WRITE, 32'(addr), 32'(d1), 32'(d2), 0, 0, 0, 0, 0, 0);
	endfunction

	function automatic void add_ram_read(input logic [17:0] addr);
		add_row(K_READ, {13'd0, 1'b1, addr}, 0, 0, JW'(ram_ref[int'(addr)]), 0, 0, 0, 0, 0);
	endfunction

	function automatic void add_mouse(input logic [7:0] dx, input logic [7:0] dy,
		input logic [1:0] btn);
		m_btn = btn;
		if (!m_dis && m_j1b == 16'h0) begin
			m_emu = 1'b1;
			m_x   = sat_ref(m_x + clamp_ref(dx));
			m_y   = sat_ref(m_y - clamp_ref(dy));
		end
		add_route_row(K_MOUSE, 32'(dx), 32'(dy), 32'(btn));
	endfunction

	function automatic void add_joy(input logic [15:0] j1b, input logic [15:0] j2b,
		input logic dis, input logic swap, input logic [31:0] axes);
		m_j1b  = j1b;
		m_j2b  = j2b;
		m_dis  = dis;
		m_swap = swap;
		{m_j1x, m_j1y, m_j2x, m_j2y} = axes;
		if (dis || j1b != 16'h0) begin
			m_emu = 1'b0;
			m_x   = 0;
			m_y   = 0;
		end
		add_route_row(K_JOY, {j2b, j1b}, {30'd0, swap, dis}, axes);
	endfunction

	//==========================================================
	// compare tasks
	//==========================================================
	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %02h actual %02h", $time, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_axis(input string name, input logic [JW-1:0] exp,
		input logic [JW-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %03h actual %03h", $time, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "port mismatch");
		end
	endtask

	// advance n falling edges
	task automatic step(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic apply_row(input row_t r);
		case (r.kind)
			K_MODEL: begin
				model_master  = r.a[0];
				mmfs_v2       = r.b[0];
				machine_reset = 1'b1;
				step(1);
				machine_reset = 1'b0;
				step(1);
			end
			K_LOAD: begin
				// b set means a load outside machine reset
				machine_reset = !r.b[0];
				load_wr       = 1'b1;
				load_addr     = r.a[17:0];
				load_data     = r.c[7:0];
				step(1);
				load_wr       = 1'b0;
				machine_reset = 1'b0;
			end
			K_READ: begin
				mem_addr = r.a[18:0];
				step(1);
				check_byte("mem_rdata", r.e0[7:0], mem_rdata);
				mem_addr = '0;
			end
			K_WRITE: begin
				mem_addr  = r.a[18:0];
				mem_we_n  = 1'b1;
				step(1);
				mem_we_n  = 1'b0;
				mem_wdata = r.b[7:0];
				step(1);
				// strobe still low, new data must not land
				mem_wdata = r.c[7:0];
				step(1);
				mem_we_n  = 1'b1;
				step(1);
				mem_addr  = '0;
			end
			K_MOUSE: begin
				stb = ~stb;
				mouse_packet = '0;
				mouse_packet[beeb_pkg::MOUSE_STB]          = stb;
				mouse_packet[beeb_pkg::MOUSE_XSIGN]        = r.a[7];
				mouse_packet[beeb_pkg::MOUSE_YSIGN]        = r.b[7];
				mouse_packet[beeb_pkg::MOUSE_DX_LO +: 7]   = r.a[6:0];
				mouse_packet[beeb_pkg::MOUSE_DY_LO +: 7]   = r.b[6:0];
				mouse_packet[beeb_pkg::MOUSE_BTN_LO +: 2]  = r.c[1:0];
				step(2);
				check_axis("js1_x", r.e0, js1_x);
				check_axis("js1_y", r.e1, js1_y);
				check_axis("js1_fire_n", r.e2, JW'(js1_fire_n));
			end
			default: begin
				{joy2_buttons, joy1_buttons}     = r.a;
				mouse_disable                    = r.b[0];
				swap_joysticks                   = r.b[1];
				{joy1_x, joy1_y, joy2_x, joy2_y} = r.c;
				// cancel lands on the next edge
				step(1);
				check_axis("js1_x", r.e0, js1_x);
				check_axis("js1_y", r.e1, js1_y);
				check_axis("js1_fire_n", r.e2, JW'(js1_fire_n));
				check_axis("js2_x", r.e3, js2_x);
				check_axis("js2_y", r.e4, js2_y);
				check_axis("js2_fire_n", r.e5, JW'(js2_fire_n));
			end
		endcase
	endtask

	function automatic void build_table();
		// model b, two offsets in every slot
		add_model(1'b0, 1'b0);
		for (int s = 0; s < beeb_pkg::ROM_SLOTS; s++) begin
			add_load(s, 0, 1'b1);
			add_load(s, 14'h2a5c, 1'b1);
		end
		add_rom_read(3, 0);
		add_rom_read(4, 14'h2a5c);
		add_rom_read(8, 0);
		add_rom_read(14, 14'h2a5c);
		add_rom_read(15, 0);
		add_rom_read(0, 0);
		add_model(1'b0, 1'b1);
		add_rom_read(8, 14'h2a5c);
		//==================================================
		// master 128, then with the v2 filing system
		//==================================================
		add_model(1'b1, 1'b0);
		for (int p = 0; p < 16; p++) begin
			add_rom_read(p, (p % 2 == 0) ? 0 : 14'h2a5c);
		end
		add_model(1'b1, 1'b1);
		add_rom_read(3, 0);
		add_rom_read(3, 14'h2a5c);
		// loader ignored with machine reset low
		add_load(6, 0, 1'b0);
		add_rom_read(4, 0);
		// ram strobe edges and a rom view write
		add_ram_write({1'b1, 18'h00123}, 8'h5a, 8'ha5);
		add_ram_read(18'h00123);
		add_ram_write({1'b1, 18'h33fff}, 8'hc3, 8'h3c);
		add_ram_read(18'h33fff);
		add_ram_write({1'b0, 4'd9, 14'h0000}, 8'hee, 8'h11);
		add_rom_read(9, 0);
		//==================================================
		// mouse accumulation
		//==================================================
		add_mouse(8'd50, 8'hfd, 2'b00);
		add_mouse(8'd5, 8'd100, 2'b01);
		for (int i = 0; i < 12; i++) begin
			add_mouse(8'd127, 8'h80, 2'b10);
		end
		add_mouse(8'h80, 8'd127, 2'b00);
		add_mouse(8'hfe, 8'h02, 2'b11);
		// both axes down onto the lower limit
		for (int i = 0; i < 26; i++) begin
			add_mouse(8'h80, 8'd127, 2'b00);
		end
		// cancel, disable, swap
		add_joy(16'h0010, 16'h0000, 1'b0, 1'b0, 32'h40c01166);
		add_joy(16'h0000, 16'h0000, 1'b1, 1'b0, 32'h40c01166);
		add_mouse(8'd7, 8'd7, 2'b01);
		add_joy(16'h0000, 16'h0010, 1'b1, 1'b1, 32'h7f8023f0);
		add_joy(16'h0000, 16'h0000, 1'b0, 1'b0, 32'h00ff8001);
		add_mouse(8'hf9, 8'd3, 2'b00);
	endfunction

	// hard limit on the whole run
	initial begin
		for (int i = 0; i < 20000; i++) begin
			@(posedge clk_sys);
		end
		$display("timeout, the run did not complete in 20000 cycles");
		$display("Finished with errors");
		$fatal(1, "watchdog");
	end

	initial begin
		int wait_n;
		machine_reset  = 1'b0;
		model_master   = 1'b0;
		mmfs_v2        = 1'b0;
		load_wr        = 1'b0;
		load_addr      = '0;
		load_data      = '0;
		mem_addr       = '0;
		mem_we_n       = 1'b1;
		mem_wdata      = '0;
		mouse_packet   = '0;
		mouse_disable  = 1'b0;
		joy1_buttons   = '0;
		joy1_x         = '0;
		joy1_y         = '0;
		joy2_buttons   = '0;
		joy2_x         = '0;
		joy2_y         = '0;
		swap_joysticks = 1'b0;
		stb            = 1'b0;
		rnd            = 32'hc217;
		m_emu          = 1'b0;
		m_x            = 0;
		m_y            = 0;
		m_btn          = 2'b00;
		m_dis          = 1'b0;
		m_swap         = 1'b0;
		m_j1b          = '0;
		m_j2b          = '0;
		{m_j1x, m_j1y, m_j2x, m_j2y} = '0;
		build_table();
		wait_n = 0;
		while (rst_n !== 1'b1 && wait_n < 50) begin
			@(negedge clk_sys);
			wait_n++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			$display("Finished with errors");
			$fatal(1, "reset timeout");
		end else begin
			step(1);
			foreach (rows[i]) begin
				apply_row(rows[i]);
			end
			if (dut.u_props.fail_count == 0) begin
				$display("Finished with no errors");
				$finish;
			end else begin
				$display("%0d bound assertion checks failed", dut.u_props.fail_count);
				$display("Finished with errors");
				$fatal(1, "checks failed");
			end
		end
	end

endmodule

//--- tb/tb_clock.sv
//==========================================================
// clock and reset source for the beeb host testbench
// 8 ns clk_sys, rst_n held low for the first 5 cycles
//==========================================================

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule
